// File: build.f
src/upscale_pkg.sv
src/frame_meter.sv
src/line_store.sv
src/input_capture.sv
src/scale_stepper.sv
src/output_stage.sv
src/upscaler_top.sv
tests/upscaler_asserts.sv
tests/upscaler_tb.sv

// File: src/frame_meter.sv
module frame_meter
	import upscale_pkg::*;
(
	input  logic        i_ClkB,
	input  logic        i_rst_n,
	input  logic        i_stb,
	input  video_ctl_t  i_ctl,
	input  logic        i_enable,
	output logic        o_sol,
	output logic        o_sof,
	output logic        o_active,
	output frame_size_t o_size,
	output logic        o_locked
);

	logic               prev_hs;
	logic               prev_vs;
	logic [H_CNT_W-1:0] pix_cnt;
	logic [H_CNT_W-1:0] line_width;
	logic [V_CNT_W-1:0] line_cnt;
	logic               line_done;
	logic [H_CNT_W-1:0] width_seen;
	logic [V_CNT_W-1:0] lines_seen;
	logic               armed;
	logic               locked;
	frame_size_t        size_q;

	// falling sync edges, qualified by the strobe
	assign o_sol    = i_stb & prev_hs & ~i_ctl.hsync_n;
	assign o_sof    = i_stb & prev_vs & ~i_ctl.vsync_n;
	assign o_active = ~i_ctl.hblank & ~i_ctl.vblank;

	// a line start that closes a line with active pixels
	assign line_done = o_sol & (pix_cnt != '0);

	// include a line that ends on the frame start itself
	assign width_seen = line_done ? pix_cnt : line_width;
	assign lines_seen = line_done ? line_cnt + 1'b1 : line_cnt;

	assign o_size   = size_q;
	assign o_locked = locked;

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			prev_hs    <= 1'b1;
			prev_vs    <= 1'b1;
			pix_cnt    <= '0;
			line_width <= '0;
			line_cnt   <= '0;
			size_q     <= '0;
			armed      <= 1'b0;
			locked     <= 1'b0;
		end else if (i_stb) begin
			prev_hs <= i_ctl.hsync_n;
			prev_vs <= i_ctl.vsync_n;

			if (o_sol) begin
				pix_cnt <= o_active ? H_CNT_W'(1) : '0;
			end else if (o_active) begin
				pix_cnt <= pix_cnt + 1'b1;
			end

			if (line_done) begin
				line_width <= pix_cnt;
			end

			if (o_sof) begin
				line_cnt <= '0;
			end else if (line_done) begin
				line_cnt <= line_cnt + 1'b1;
			end

			// first frame start arms, the next one locks and freezes the size
			if (o_sof && !locked) begin
				size_q <= '{width: width_seen, height: lines_seen};
				armed  <= 1'b1;
				if (armed && i_enable) begin
					locked <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/input_capture.sv
module input_capture
	import upscale_pkg::*;
(
	input  logic                  i_ClkB,
	input  logic                  i_rst_n,
	input  logic                  i_stb,
	input  logic                  i_sol,
	input  logic                  i_sof,
	input  logic                  i_active,
	input  rgb_t                  i_rgb,
	output logic                  o_wr_en,
	output logic [LINE_IDX_W-1:0] o_wr_line,
	output logic [LINE_COL_W-1:0] o_wr_col,
	output rgb_t                  o_wr_rgb,
	output logic [LINE_IDX_W-1:0] o_sof_line
);

	logic [LINE_IDX_W-1:0] line_q;
	logic [LINE_IDX_W-1:0] line_next;
	logic [LINE_IDX_W-1:0] line_cur;
	logic [LINE_COL_W-1:0] col_q;
	logic [LINE_COL_W-1:0] col_cur;
	logic                  had_active;
	logic [LINE_IDX_W-1:0] sof_line_q;

	assign line_next = (line_q == LINE_IDX_W'(LINE_COUNT - 1)) ? '0 : line_q + 1'b1;

	// position of the pixel in this cycle, line start taken into account
	assign line_cur = (i_sol && had_active) ? line_next : line_q;
	assign col_cur  = i_sol ? '0 : col_q;

	assign o_wr_en    = i_stb & i_active;
	assign o_wr_line  = line_cur;
	assign o_wr_col   = col_cur;
	assign o_wr_rgb   = i_rgb;
	assign o_sof_line = sof_line_q;

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			line_q     <= '0;
			col_q      <= '0;
			had_active <= 1'b0;
			sof_line_q <= '0;
		end else if (i_stb) begin
			line_q <= line_cur;

			if (o_wr_en) begin
				col_q <= (col_cur == LINE_COL_W'(LINE_LEN - 1)) ? '0 : col_cur + 1'b1;
			end else begin
				col_q <= col_cur;
			end

			// remembers whether the running line wrote anything
			had_active <= (i_sol ? 1'b0 : had_active) | i_active;

			// ring line that takes the first active line of the new frame
			if (i_sof) begin
				sof_line_q <= line_cur;
			end
		end
	end

endmodule

// File: src/line_store.sv
module line_store
	import upscale_pkg::*;
(
	input  logic                  i_ClkB,
	input  logic                  i_wr_en,
	input  logic [LINE_IDX_W-1:0] i_wr_line,
	input  logic [LINE_COL_W-1:0] i_wr_col,
	input  rgb_t                  i_wr_rgb,
	input  logic                  i_rd_en,
	input  logic [LINE_IDX_W-1:0] i_rd_line,
	input  logic [LINE_COL_W-1:0] i_rd_col,
	output rgb_t                  o_rd_rgb
);

	// ring of line buffers, one entry per pixel
	rgb_t mem [LINE_COUNT][LINE_LEN];

	rgb_t rd_q;

	always_ff @(posedge i_ClkB) begin
		if (i_wr_en) begin
			mem[i_wr_line][i_wr_col] <= i_wr_rgb;
		end
	end

	// registered read, holds its value between reads
	always_ff @(posedge i_ClkB) begin
		if (i_rd_en) begin
			rd_q <= mem[i_rd_line][i_rd_col];
		end
	end

	assign o_rd_rgb = rd_q;

endmodule

// File: src/output_stage.sv
module output_stage
	import upscale_pkg::*;
(
	input  logic       i_ClkB,
	input  logic       i_rst_n,
	input  video_ctl_t i_ref_ctl,
	input  rgb_t       i_rd_rgb,
	output video_ctl_t o_line_ctl,
	output video_ctl_t o_out_ctl,
	output rgb_t       o_out_rgb
);

	logic                   prev_hs;
	logic                   prev_vs;
	logic                   prev_vb;
	logic                   hs_fall;
	logic [VSYNC_DELAY-1:0] vs_dly;
	logic [VSYNC_DELAY-1:0] vb_dly;
	logic [VSYNC_DELAY-1:0] vs_next;
	logic [VSYNC_DELAY-1:0] vb_next;
	video_ctl_t             ctl_d1;

	assign hs_fall = prev_hs & ~i_ref_ctl.hsync_n;

	// line shift registers take the levels of the line that just ended
	// the new state shows in the edge cycle itself
	assign vs_next = hs_fall ? VSYNC_DELAY'({vs_dly, prev_vs}) : vs_dly;
	assign vb_next = hs_fall ? VSYNC_DELAY'({vb_dly, prev_vb}) : vb_dly;

	assign o_line_ctl = '{
		hsync_n: i_ref_ctl.hsync_n,
		vsync_n: vs_next[VSYNC_DELAY-1],
		hblank:  i_ref_ctl.hblank,
		vblank:  vb_next[VSYNC_DELAY-1]
	};

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			prev_hs   <= 1'b1;
			prev_vs   <= 1'b1;
			prev_vb   <= 1'b0;
			vs_dly    <= '1;
			vb_dly    <= '0;
			ctl_d1    <= CTL_IDLE;
			o_out_ctl <= CTL_IDLE;
			o_out_rgb <= '0;
		end else begin
			prev_hs <= i_ref_ctl.hsync_n;
			prev_vs <= i_ref_ctl.vsync_n;
			prev_vb <= i_ref_ctl.vblank;
			vs_dly  <= vs_next;
			vb_dly  <= vb_next;

			// first stage waits for the registered read
			ctl_d1    <= o_line_ctl;
			o_out_ctl <= ctl_d1;

			// black outside the active area
			if (ctl_d1.hblank || ctl_d1.vblank) begin
				o_out_rgb <= '0;
			end else begin
				o_out_rgb <= i_rd_rgb;
			end
		end
	end

endmodule

// File: src/scale_stepper.sv
module scale_stepper
	import upscale_pkg::*;
(
	input  logic                  i_ClkB,
	input  logic                  i_rst_n,
	input  logic                  i_stb,
	input  logic                  i_sol,
	input  logic                  i_sof,
	input  logic                  i_active,
	input  frame_size_t           i_in_size,
	input  frame_size_t           i_out_size,
	input  logic                  i_locked,
	input  logic [LINE_IDX_W-1:0] i_sof_line,
	output logic                  o_rd_en,
	output logic [LINE_IDX_W-1:0] o_rd_line,
	output logic [LINE_COL_W-1:0] o_rd_col
);

	localparam int CNT_W = (H_CNT_W > V_CNT_W) ? H_CNT_W : V_CNT_W;

	step_t                 h_step;
	step_t                 v_step;
	logic                  lock_q;
	logic [H_ACC_W-1:0]    h_acc;
	logic [V_ACC_W-1:0]    v_acc;
	logic [LINE_IDX_W-1:0] base_line;
	logic                  had_active;
	logic [H_CNT_W-1:0]    h_int;
	logic [V_CNT_W-1:0]    v_int;
	logic [V_CNT_W:0]      line_sum;

	// src * 2^FRAC_W / dst, saturated to the step range
	function automatic step_t calc_step(input logic [CNT_W-1:0] src,
	                                    input logic [CNT_W-1:0] dst);
		logic [CNT_W+FRAC_W-1:0] quo;
		if (dst == '0) begin
			return '0;
		end
		quo = {src, {FRAC_W{1'b0}}} / dst;
		if (|(quo >> (FRAC_W + 1))) begin
			return '1;
		end
		return step_t'(quo);
	endfunction

	// integer parts of the accumulators
	assign h_int = h_acc[H_ACC_W-1:FRAC_W];
	assign v_int = v_acc[V_ACC_W-1:FRAC_W];

	assign line_sum = (V_CNT_W + 1)'(base_line) + v_int;

	assign o_rd_en   = i_stb & i_active & i_locked;
	assign o_rd_line = LINE_IDX_W'(line_sum % LINE_COUNT);
	assign o_rd_col  = LINE_COL_W'(h_int % LINE_LEN);

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			lock_q     <= 1'b0;
			h_step     <= '0;
			v_step     <= '0;
			h_acc      <= '0;
			v_acc      <= '0;
			base_line  <= '0;
			had_active <= 1'b0;
		end else begin
			lock_q <= i_locked;

			// sizes are frozen once the output locks, divide only then
			if (i_locked && !lock_q) begin
				h_step <= calc_step(CNT_W'(i_in_size.width), CNT_W'(i_out_size.width));
				v_step <= calc_step(CNT_W'(i_in_size.height), CNT_W'(i_out_size.height));
			end

			if (i_stb) begin
				if (i_sol) begin
					h_acc <= '0;
				end else if (i_active) begin
					h_acc <= h_acc + h_step;
				end

				had_active <= (i_sol ? 1'b0 : had_active) | i_active;

				// vertical position moves once per finished active line
				if (i_sof) begin
					v_acc     <= '0;
					base_line <= i_sof_line;
				end else if (i_sol && had_active) begin
					v_acc <= v_acc + v_step;
				end
			end
		end
	end

endmodule

// File: src/upscale_pkg.sv
package upscale_pkg;

	// colour depth and line buffer geometry
	localparam int COMP_W     = 8;
	localparam int LINE_LEN   = 64;
	localparam int LINE_COUNT = 12;
	localparam int LINE_IDX_W = 4;
	localparam int LINE_COL_W = $clog2(LINE_LEN);

	// frame measurement counters
	localparam int H_CNT_W = 12;
	localparam int V_CNT_W = 12;

	// fixed-point scale steps
	localparam int FRAC_W  = 6;
	localparam int H_ACC_W = H_CNT_W + FRAC_W;
	localparam int V_ACC_W = V_CNT_W + FRAC_W;

	// output lines of vsync and vblank delay
	localparam int VSYNC_DELAY = 2;

	typedef struct packed {
		logic [COMP_W-1:0] red;
		logic [COMP_W-1:0] green;
		logic [COMP_W-1:0] blue;
	} rgb_t;

	// syncs are active low, blanks active high
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
	} video_ctl_t;

	typedef struct packed {
		logic [H_CNT_W-1:0] width;
		logic [V_CNT_W-1:0] height;
	} frame_size_t;

	// unsigned, FRAC_W fraction bits and one integer bit
	typedef logic [FRAC_W:0] step_t;

	// idle timing, nothing asserted
	localparam video_ctl_t CTL_IDLE = '{
		hsync_n: 1'b1,
		vsync_n: 1'b1,
		hblank:  1'b0,
		vblank:  1'b0
	};

endpackage

// File: src/upscaler_top.sv
module upscaler_top
	import upscale_pkg::*;
(
	input  logic        i_ClkB,
	input  logic        i_rst_n,
	input  logic        i_in_stb,
	input  video_ctl_t  i_in_ctl,
	input  rgb_t        i_in_rgb,
	input  logic        i_ref_stb,
	input  video_ctl_t  i_ref_ctl,
	output video_ctl_t  o_out_ctl,
	output rgb_t        o_out_rgb,
	output logic        o_in_locked,
	output frame_size_t o_in_size,
	output logic        o_out_locked,
	output frame_size_t o_out_size
);

	// input side
	logic                  in_sol;
	logic                  in_sof;
	logic                  in_active;
	logic                  wr_en;
	logic [LINE_IDX_W-1:0] wr_line;
	logic [LINE_COL_W-1:0] wr_col;
	rgb_t                  wr_rgb;
	logic [LINE_IDX_W-1:0] sof_line;

	// output side
	video_ctl_t            line_ctl;
	logic                  out_sol;
	logic                  out_sof;
	logic                  out_active;
	logic                  rd_en;
	logic [LINE_IDX_W-1:0] rd_line;
	logic [LINE_COL_W-1:0] rd_col;
	rgb_t                  rd_rgb;

	frame_meter in_meter (
		.i_ClkB   (i_ClkB),
		.i_rst_n  (i_rst_n),
		.i_stb    (i_in_stb),
		.i_ctl    (i_in_ctl),
		.i_enable (1'b1),
		.o_sol    (in_sol),
		.o_sof    (in_sof),
		.o_active (in_active),
		.o_size   (o_in_size),
		.o_locked (o_in_locked)
	);

	input_capture u_input_capture (
		.i_ClkB     (i_ClkB),
		.i_rst_n    (i_rst_n),
		.i_stb      (i_in_stb),
		.i_sol      (in_sol),
		.i_sof      (in_sof),
		.i_active   (in_active),
		.i_rgb      (i_in_rgb),
		.o_wr_en    (wr_en),
		.o_wr_line  (wr_line),
		.o_wr_col   (wr_col),
		.o_wr_rgb   (wr_rgb),
		.o_sof_line (sof_line)
	);

	line_store u_line_store (
		.i_ClkB    (i_ClkB),
		.i_wr_en   (wr_en),
		.i_wr_line (wr_line),
		.i_wr_col  (wr_col),
		.i_wr_rgb  (wr_rgb),
		.i_rd_en   (rd_en),
		.i_rd_line (rd_line),
		.i_rd_col  (rd_col),
		.o_rd_rgb  (rd_rgb)
	);

	// output meter sees the line-delayed reference timing
	frame_meter out_meter (
		.i_ClkB   (i_ClkB),
		.i_rst_n  (i_rst_n),
		.i_stb    (i_ref_stb),
		.i_ctl    (line_ctl),
		.i_enable (o_in_locked),
		.o_sol    (out_sol),
		.o_sof    (out_sof),
		.o_active (out_active),
		.o_size   (o_out_size),
		.o_locked (o_out_locked)
	);

	scale_stepper u_scale_stepper (
		.i_ClkB     (i_ClkB),
		.i_rst_n    (i_rst_n),
		.i_stb      (i_ref_stb),
		.i_sol      (out_sol),
		.i_sof      (out_sof),
		.i_active   (out_active),
		.i_in_size  (o_in_size),
		.i_out_size (o_out_size),
		.i_locked   (o_out_locked),
		.i_sof_line (sof_line),
		.o_rd_en    (rd_en),
		.o_rd_line  (rd_line),
		.o_rd_col   (rd_col)
	);

	output_stage u_output_stage (
		.i_ClkB     (i_ClkB),
		.i_rst_n    (i_rst_n),
		.i_ref_ctl  (i_ref_ctl),
		.i_rd_rgb   (rd_rgb),
		.o_line_ctl (line_ctl),
		.o_out_ctl  (o_out_ctl),
		.o_out_rgb  (o_out_rgb)
	);

endmodule

// File: tests/upscaler_asserts.sv
module upscaler_asserts
	import upscale_pkg::*;
(
	input logic       i_ClkB,
	input logic       i_rst_n,
	input video_ctl_t i_out_ctl,
	input rgb_t       i_out_rgb,
	input logic       i_in_locked,
	input logic       i_out_locked
);
	timeunit 1ns;
	timeprecision 1ps;

	// black whenever either blank is set
	blank_is_black: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		(i_out_ctl.hblank || i_out_ctl.vblank) |-> (i_out_rgb == '0))
		else $error("output pixel is not zero during blanking");

	in_lock_holds: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		i_in_locked |=> i_in_locked)
		else $error("input lock fell without a reset");

	out_lock_holds: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		i_out_locked |=> i_out_locked)
		else $error("output lock fell without a reset");

	// idle timing and black pixel once reset has been seen
	reset_idle: assert property (@(posedge i_ClkB)
		!i_rst_n |=> (i_out_ctl == CTL_IDLE) && (i_out_rgb == '0))
		else $error("outputs not idle after reset");

endmodule

bind upscaler_top upscaler_asserts u_asserts (
	.i_ClkB       (i_ClkB),
	.i_rst_n      (i_rst_n),
	.i_out_ctl    (o_out_ctl),
	.i_out_rgb    (o_out_rgb),
	.i_in_locked  (o_in_locked),
	.i_out_locked (o_out_locked)
);

// File: tests/upscaler_tb.sv
module upscaler_tb
	import upscale_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	// frame geometry in strobes per line and lines per frame
	localparam int IN_PIX    = 12;
	localparam int IN_LINES  = 7;
	localparam int REF_PIX   = 22;
	localparam int REF_LINES = 12;

	logic        i_ClkB = 1'b0;
	logic        i_rst_n;
	logic        i_in_stb;
	video_ctl_t  i_in_ctl;
	rgb_t        i_in_rgb;
	logic        i_ref_stb;
	video_ctl_t  i_ref_ctl;
	video_ctl_t  o_out_ctl;
	rgb_t        o_out_rgb;
	logic        o_in_locked;
	frame_size_t o_in_size;
	logic        o_out_locked;
	frame_size_t o_out_size;

	int         errors = 0;
	int         timeouts = 0;
	int         seed = 32'hb5c1;
	rgb_t       model [4][8];
	video_ctl_t exp_ctl_q [$];
	rgb_t       exp_rgb_q [$];

	upscaler_top uut (
		.i_ClkB       (i_ClkB),
		.i_rst_n      (i_rst_n),
		.i_in_stb     (i_in_stb),
		.i_in_ctl     (i_in_ctl),
		.i_in_rgb     (i_in_rgb),
		.i_ref_stb    (i_ref_stb),
		.i_ref_ctl    (i_ref_ctl),
		.o_out_ctl    (o_out_ctl),
		.o_out_rgb    (o_out_rgb),
		.o_in_locked  (o_in_locked),
		.o_in_size    (o_in_size),
		.o_out_locked (o_out_locked),
		.o_out_size   (o_out_size)
	);

	always #4 i_ClkB = ~i_ClkB;

	// timing of pixel p on line l, vsync low on line 0
	function automatic video_ctl_t make_ctl(input int p, input int l, input int h0,
	                                        input int h1, input int v0, input int v1);
		video_ctl_t c;
		c.hsync_n = (p >= 2);
		c.vsync_n = (l != 0);
		c.hblank  = (p < h0) || (p >= h1);
		c.vblank  = (l < v0) || (l >= v1);
		return c;
	endfunction

	task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ctl(input video_ctl_t got, input video_ctl_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_size(input frame_size_t got, input frame_size_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %0d x %0d, expected %0d x %0d", $time, what,
			         got.width, got.height, exp.width, exp.height);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// 8 by 4 active pixels, the model keeps the latest frame
	task automatic drive_in_frame();
		video_ctl_t c;
		rgb_t       px;
		for (int l = 0; l < IN_LINES; l++) begin
			for (int p = 0; p < IN_PIX; p++) begin
				@(posedge i_ClkB);
				#1;
				c  = make_ctl(p, l, 3, 11, 2, 6);
				px = rgb_t'($random(seed));
				if (!c.hblank && !c.vblank) begin
					model[l-2][p-3] = px;
				end
				i_in_stb = 1'b1;
				i_in_ctl = c;
				i_in_rgb = px;
			end
		end
	endtask

	// 16 by 8 active reference frame, outputs compared two cycles after each step
	task automatic drive_ref_frame(input bit check);
		video_ctl_t e;
		rgb_t       er;
		int         dl;
		for (int l = 0; l < REF_LINES; l++) begin
			for (int p = 0; p < REF_PIX; p++) begin
				@(posedge i_ClkB);
				#1;
				if (exp_ctl_q.size() == 2) begin
					e  = exp_ctl_q.pop_front();
					er = exp_rgb_q.pop_front();
					if (check) begin
						check_ctl(o_out_ctl, e, "o_out_ctl");
						check_rgb(o_out_rgb, er, "o_out_rgb");
					end
				end
				i_ref_ctl = make_ctl(p, l, 4, 20, 2, 10);
				// vsync and vblank lag the reference by whole lines
				dl = (l + REF_LINES - VSYNC_DELAY) % REF_LINES;
				e  = make_ctl(p, dl, 4, 20, 2, 10);
				er = '0;
				if (!e.hblank && !e.vblank) begin
					// both steps are one half
					er = model[(dl - 2) / 2][(p - 4) / 2];
				end
				exp_ctl_q.push_back(e);
				exp_rgb_q.push_back(er);
			end
		end
	endtask

	initial begin
		int n;
		i_rst_n   = 1'b0;
		i_in_stb  = 1'b0;
		i_in_ctl  = CTL_IDLE;
		i_in_rgb  = '0;
		i_ref_stb = 1'b1;
		i_ref_ctl = CTL_IDLE;
		repeat (2) @(posedge i_ClkB);
		#1;
		i_rst_n = 1'b1;

		check_ctl(o_out_ctl, CTL_IDLE, "o_out_ctl after reset");
		check_rgb(o_out_rgb, '0, "o_out_rgb after reset");
		check_flag(o_in_locked, 1'b0, "o_in_locked after reset");
		check_flag(o_out_locked, 1'b0, "o_out_locked after reset");
		check_size(o_in_size, '0, "o_in_size after reset");
		check_size(o_out_size, '0, "o_out_size after reset");

		drive_in_frame();
		drive_in_frame();
		@(posedge i_ClkB);
		#1;
		i_in_stb = 1'b0;
		for (n = 0; n < 32 && !o_in_locked; n++) begin
			@(posedge i_ClkB);
			#1;
		end
		if (!o_in_locked) begin
			timeouts++;
			$display("timeout: the input side never locked");
		end
		check_size(o_in_size, '{width: 12'd8, height: 12'd4}, "o_in_size");

		drive_ref_frame(1'b0);
		drive_ref_frame(1'b1);
		for (n = 0; n < 32 && !o_out_locked; n++) begin
			@(posedge i_ClkB);
			#1;
		end
		if (!o_out_locked) begin
			timeouts++;
			$display("timeout: the output side never locked");
		end
		check_size(o_out_size, '{width: 12'd16, height: 12'd8}, "o_out_size");
		drive_ref_frame(1'b1);

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
